// File: run_sim.sh
#!/bin/sh
# Build and run the exponent stage testbench with Verilator
verilator --binary --timing --assert -f tcu_exp.f --top-module tcu_exp_tb \
    -Mdir obj_dir -o tcu_exp_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tcu_exp_sim > sim.log 2>&1 || true
grep -q "^TEST PASS$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tcu_exp.f
+incdir+.
tcu_fmt_pkg.sv
tcu_fedp_pkg.sv
tcu_operand_if.sv
tcu_operand_classify.sv
tcu_exp_bias.sv
tcu_exp_align.sv
tcu_exp_top.sv
tcu_exp_tb.sv

// File: tcu_exp_align.sv
`timescale 1ns/10ps
`include "tcu_macros.svh"

module tcu_exp_align (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  valid,
    input  tcu_fedp_pkg::exp_t     [`TCU_TCK:0]   raw_exp,
    input  tcu_fedp_pkg::f8_diff_t [`TCU_TCK-1:0] exp_diff_f8,
    input  logic                                  any_special_in,
    output logic                                  out_valid,
    output tcu_fedp_pkg::exp_t                    max_exp,
    output tcu_fedp_pkg::shift_t   [`TCU_TCK:0]   shift_amt,
    output logic                   [`TCU_TCK:0]   zero_mask,
    output tcu_fedp_pkg::f8_diff_t [`TCU_TCK-1:0] diff_f8,
    output logic                                  any_special
);
    import tcu_fedp_pkg::*;

    localparam int TCK   = `TCU_TCK;
    localparam int EXP_W = `TCU_EXP_W;

    exp_t           max_d;
    shift_t [TCK:0] shift_d;
    logic   [TCK:0] zero_d;

    // Signed max over nonzero terms
    always_comb begin : max_search
        logic found;
        max_d = '0;
        found = 1'b0;
        for (int t = 0; t <= TCK; t++) begin
            if (raw_exp[t] != '0 && (!found || $signed(raw_exp[t]) > $signed(max_d))) begin
                max_d = raw_exp[t];
                found = 1'b1;
            end
        end
    end

    // Saturated distance to the max
    always_comb begin : shift_calc
        logic signed [EXP_W:0] delta;
        for (int t = 0; t <= TCK; t++) begin
            delta     = $signed({max_d[EXP_W-1], max_d}) -
                        $signed({raw_exp[t][EXP_W-1], raw_exp[t]});
            zero_d[t] = (raw_exp[t] == '0);
            if (zero_d[t] || delta > 63) begin
                shift_d[t] = SHIFT_MAX;
            end else begin
                shift_d[t] = shift_t'(delta);
            end
        end
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            max_exp     <= max_d;
            shift_amt   <= shift_d;
            zero_mask   <= zero_d;
            diff_f8     <= exp_diff_f8;
            any_special <= any_special_in;
        end
    end

    for (genvar t = 0; t <= TCK; t++) begin : g_chk
        a_term_le_max: assert property (@(posedge clk) disable iff (rst)
            valid && raw_exp[t] != '0 |=>
            $signed(max_exp) >= $signed($past(raw_exp[t])))
            else $error("term %0d above max_exp", t);
    end

endmodule

// File: tcu_exp_bias.sv
`timescale 1ns/10ps
`include "tcu_macros.svh"

module tcu_exp_bias (
    tcu_operand_if.consumer                       ops,
    output tcu_fedp_pkg::exp_t     [`TCU_TCK:0]   raw_exp,
    output tcu_fedp_pkg::f8_diff_t [`TCU_TCK-1:0] exp_diff_f8
);
    import tcu_fmt_pkg::*;
    import tcu_fedp_pkg::*;

    localparam int TCK   = `TCU_TCK;
    localparam int W     = `TCU_W;
    localparam int EXP_W = `TCU_EXP_W;

    function automatic exp_t bias_const(fmt_id_t f, int align);
        return exp_t'(127 - 2 * exp_bias(f) + align - W);
    endfunction

    // 8-bit formats pack two sub-products, hence double alignment
    localparam exp_t BC_TF32 = bias_const(FMT_TF32, 1);
    localparam exp_t BC_FP16 = bias_const(FMT_FP16, 1);
    localparam exp_t BC_BF16 = bias_const(FMT_BF16, 1);
    localparam exp_t BC_FP8  = bias_const(FMT_FP8, 2);
    localparam exp_t BC_BF8  = bias_const(FMT_BF8, 2);

    // Subnormals behave as exponent 1
    function automatic logic [7:0] elem_exp(logic [31:0] word, int off, fmt_id_t f,
                                            elem_class_t cls);
        logic [31:0] fld;
        fld = (word >> (off + man_bits(f))) & ((32'd1 << exp_bits(f)) - 32'd1);
        return cls.is_sub ? 8'd1 : fld[7:0];
    endfunction

    // ----------------------------------------
    // Per-lane product exponents
    // ----------------------------------------
    for (genvar i = 0; i < TCK; i++) begin : g_lane
        localparam int OFF = (i % 2) * 16;

        logic [31:0]     ra;
        logic [31:0]     rb;
        logic [7:0]      ea_tf32, eb_tf32, ea_fp16, eb_fp16, ea_bf16, eb_bf16;
        logic            z_tf32, z_fp16, z_bf16;
        logic [1:0][7:0] ea_fp8, eb_fp8, ea_bf8, eb_bf8;
        logic [1:0]      z_fp8, z_bf8;
        logic [7:0]      ea_w, eb_w;
        logic            z_w;
        exp_t            bias_w;
        logic [1:0][7:0] ea_n, eb_n;
        logic [1:0]      z_n;
        exp_t            bias_n;
        exp_t            sum_w;
        exp_t [1:0]      sum_n;
        exp_t            diff;
        exp_t            diff_abs;
        exp_t            lane_exp;

        assign ra = ops.a_row[i/2];
        assign rb = ops.b_col[i/2];

        // TF32 has one element per word
        if (i % 2 == 0) begin : g_tf32
            assign ea_tf32 = elem_exp(ra, 0, FMT_TF32, ops.cls_tf32[0][i/2]);
            assign eb_tf32 = elem_exp(rb, 0, FMT_TF32, ops.cls_tf32[1][i/2]);
            assign z_tf32  = ops.cls_tf32[0][i/2].is_zero | ops.cls_tf32[1][i/2].is_zero |
                             ~ops.vld_mask[i*4];
        end else begin : g_tf32_odd
            assign ea_tf32 = 8'd0;
            assign eb_tf32 = 8'd0;
            assign z_tf32  = 1'b1;
        end

        assign ea_fp16 = elem_exp(ra, OFF, FMT_FP16, ops.cls_fp16[0][i]);
        assign eb_fp16 = elem_exp(rb, OFF, FMT_FP16, ops.cls_fp16[1][i]);
        assign z_fp16  = ops.cls_fp16[0][i].is_zero | ops.cls_fp16[1][i].is_zero |
                         ~ops.vld_mask[i*4];
        assign ea_bf16 = elem_exp(ra, OFF, FMT_BF16, ops.cls_bf16[0][i]);
        assign eb_bf16 = elem_exp(rb, OFF, FMT_BF16, ops.cls_bf16[1][i]);
        assign z_bf16  = ops.cls_bf16[0][i].is_zero | ops.cls_bf16[1][i].is_zero |
                         ~ops.vld_mask[i*4];

        for (genvar j = 0; j < 2; j++) begin : g_sub
            localparam int IDX = i * 2 + j;
            assign ea_fp8[j] = elem_exp(ra, OFF + j * 8, FMT_FP8, ops.cls_fp8[0][IDX]);
            assign eb_fp8[j] = elem_exp(rb, OFF + j * 8, FMT_FP8, ops.cls_fp8[1][IDX]);
            assign z_fp8[j]  = ops.cls_fp8[0][IDX].is_zero | ops.cls_fp8[1][IDX].is_zero |
                               ~ops.vld_mask[IDX*2];
            assign ea_bf8[j] = elem_exp(ra, OFF + j * 8, FMT_BF8, ops.cls_bf8[0][IDX]);
            assign eb_bf8[j] = elem_exp(rb, OFF + j * 8, FMT_BF8, ops.cls_bf8[1][IDX]);
            assign z_bf8[j]  = ops.cls_bf8[0][IDX].is_zero | ops.cls_bf8[1][IDX].is_zero |
                               ~ops.vld_mask[IDX*2];
            assign sum_n[j]  = bias_n + exp_t'(ea_n[j]) + exp_t'(eb_n[j]);
        end

        // Format select, unused path held at zero
        always_comb begin
            ea_w   = ea_tf32;
            eb_w   = eb_tf32;
            z_w    = z_tf32;
            bias_w = BC_TF32;
            ea_n   = '0;
            eb_n   = '0;
            z_n    = 2'b11;
            bias_n = '0;
            case (ops.fmt)
                FMT_FP16: begin
                    ea_w   = ea_fp16;
                    eb_w   = eb_fp16;
                    z_w    = z_fp16;
                    bias_w = BC_FP16;
                end
                FMT_BF16: begin
                    ea_w   = ea_bf16;
                    eb_w   = eb_bf16;
                    z_w    = z_bf16;
                    bias_w = BC_BF16;
                end
                FMT_FP8: begin
                    z_w    = 1'b1;
                    ea_n   = ea_fp8;
                    eb_n   = eb_fp8;
                    z_n    = z_fp8;
                    bias_n = BC_FP8;
                end
                FMT_BF8: begin
                    z_w    = 1'b1;
                    ea_n   = ea_bf8;
                    eb_n   = eb_bf8;
                    z_n    = z_bf8;
                    bias_n = BC_BF8;
                end
                default: begin
                    z_w = z_tf32;
                end
            endcase
        end

        assign sum_w    = bias_w + exp_t'(ea_w) + exp_t'(eb_w);
        assign diff     = sum_n[1] - sum_n[0];
        assign diff_abs = diff[EXP_W-1] ? -diff : diff;

        assign exp_diff_f8[i] = {diff[EXP_W-1], diff_abs[4:0]};

        // Larger of the two present sub-products
        always_comb begin
            if (z_n[0] && z_n[1]) begin
                lane_exp = z_w ? '0 : sum_w;
            end else if (z_n[0]) begin
                lane_exp = sum_n[1];
            end else if (z_n[1] || diff[EXP_W-1]) begin
                lane_exp = sum_n[0];
            end else begin
                lane_exp = sum_n[1];
            end
        end

        assign raw_exp[i] = lane_exp;
    end

    // ----------------------------------------
    // C term
    // ----------------------------------------
    assign raw_exp[TCK] = ops.cls_c.is_zero ? '0 :
                          exp_t'(ops.c_val[30:23]) - exp_t'(W - 1);

    a_fmt_known: assert property (@(posedge ops.clk) ops.valid |-> fmt_defined(ops.fmt))
        else $error("bias stage sees undefined fmt %0d", ops.fmt);

endmodule

// File: tcu_exp_tb.sv
`timescale 1ns/10ps
`include "tcu_macros.svh"

module tcu_exp_tb;
    import tcu_fmt_pkg::*;
    import tcu_fedp_pkg::*;

    localparam int NUM_VEC   = 13;
    localparam int VEC_WORDS = 12;
    localparam int TIMEOUT   = 50;

    logic                                  clk;
    logic                                  rst;
    logic                                  in_valid;
    fmt_id_t                               fmt;
    logic [`TCU_MASK_W-1:0]                vld_mask;
    logic [`TCU_N-1:0][31:0]               a_row;
    logic [`TCU_N-1:0][31:0]               b_col;
    logic [31:0]                           c_val;
    logic                                  out_valid;
    exp_t                                  max_exp;
    shift_t   [`TCU_TCK:0]                 shift_amt;
    logic     [`TCU_TCK:0]                 zero_mask;
    f8_diff_t [`TCU_TCK-1:0]               diff_f8;
    logic                                  any_special;

    // Per vector: fmt mask a1 a0 b1 b0 c max shift zmask diff special
    logic [31:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];

    int errors    = 0;
    int checked   = 0;
    int cycle_cnt = 0;
    int idx_q[$];
    int cyc_q[$];
    logic timed_out = 1'b0;

    tcu_exp_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .fmt         (fmt),
        .vld_mask    (vld_mask),
        .a_row       (a_row),
        .b_col       (b_col),
        .c_val       (c_val),
        .out_valid   (out_valid),
        .max_exp     (max_exp),
        .shift_amt   (shift_amt),
        .zero_mask   (zero_mask),
        .diff_f8     (diff_f8),
        .any_special (any_special)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic compare(string name, int vec, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s on vector %0d: got 0x%h, expected 0x%h", name, vec, got, exp);
            errors++;
        end
    endtask

    task automatic apply_vector(int v);
        int b;
        b        = v * VEC_WORDS;
        in_valid = 1'b1;
        fmt      = vec_mem[b][2:0];
        vld_mask = vec_mem[b+1][15:0];
        a_row    = {vec_mem[b+2], vec_mem[b+3]};
        b_col    = {vec_mem[b+4], vec_mem[b+5]};
        c_val    = vec_mem[b+6];
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic send_all();
        int gap;
        for (int v = 0; v < NUM_VEC; v++) begin
            // Second half goes back to back
            if (v < NUM_VEC / 2) begin
                gap = $urandom % 3;
            end else begin
                gap = 0;
            end
            repeat (gap) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            apply_vector(v);
            idx_q.push_back(v);
            cyc_q.push_back(cycle_cnt);
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    // ----------------------------------------
    // Response checking
    // ----------------------------------------
    task automatic collect_all();
        int waited;
        int v;
        int dc;
        int b;
        for (int n = 0; n < NUM_VEC; n++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!out_valid && waited < TIMEOUT);
            if (!out_valid) begin
                $display("Timeout: no out_valid for result %0d within %0d cycles", n, TIMEOUT);
                timed_out = 1'b1;
                break;
            end
            v  = idx_q.pop_front();
            dc = cyc_q.pop_front();
            b  = v * VEC_WORDS;
            if (cycle_cnt != dc + 2) begin
                $display("Vector %0d came out %0d cycles after it was driven, not 2",
                         v, cycle_cnt - dc);
                errors++;
            end
            compare("max_exp", v, 32'(max_exp), vec_mem[b+7]);
            compare("shift_amt", v, 32'(shift_amt), vec_mem[b+8]);
            compare("zero_mask", v, 32'(zero_mask), vec_mem[b+9]);
            compare("diff_f8", v, 32'(diff_f8), vec_mem[b+10]);
            compare("any_special", v, 32'(any_special), vec_mem[b+11]);
            checked++;
        end
    endtask

    initial begin
        in_valid = 1'b0;
        fmt      = FMT_TF32;
        vld_mask = '0;
        a_row    = '0;
        b_col    = '0;
        c_val    = '0;
        rst      = 1'b1;
        void'($urandom(32'h4885_1ec6));
        $readmemh("tcu_exp_testdata.hex", vec_mem);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        fork
            send_all();
            collect_all();
        join

        $display("Checked %0d of %0d vectors, %0d errors", checked, NUM_VEC, errors);
        if (errors == 0 && !timed_out && checked == NUM_VEC) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tcu_exp_testdata.hex
// fmt vld_mask a_row[1] a_row[0] b_col[1] b_col[0] c_val
// then expected max_exp shift_amt zero_mask diff_f8 any_special
1 FFFF 38004400 40003C00 44003C00 3C003C00 3F800000 069 02040042 00 000000 0
2 FFFF 3F004080 40003F80 3F803F00 3F803F80 40000000 068 00080001 00 000000 0
3 FFFF 50303838 38484038 48303838 38403838 3F800000 06D 06005084 00 1C08C1 0
4 FFFF 3C3C3C50 4440383C 3C3C3C50 4040383C 00000000 072 3F2801CA 10 02A062 0
0 FFFF 00020800 0001FC00 0001FC00 00020000 3F800000 06A 03FC0FC2 0A 000000 0
1 FEFF 40003C00 00010000 3C003C00 3C003C00 3F800000 068 0103F3FF 05 000000 0
1 FFFF 3C003C00 3C007C00 3C003C00 3C003C00 3F800000 077 10410400 00 000000 1
3 FFFF 38383838 0000007F 38383838 00003838 3F800000 070 09208FC0 02 00002F 1
3 FBFF 38383830 38383838 38383838 38383838 00000000 068 3F001000 10 001000 0
1 FFFF 3C003C00 3C000001 3C003C00 3C000001 7F000000 0E6 00FFFFFF 00 000000 0
2 0000 3F803F80 3F803F80 3F803F80 3F803F80 00000000 000 3FFFFFFF 1F 000000 0
4 FFFF 3C3C3C3C 3C3C3C3C 7C3C3C3C 3C3C3C3C 3F800000 078 11010410 00 400000 1
0 FFFF 00000800 00000400 00000400 00000400 00000000 36C 3FFC0FC1 1A 000000 0

// File: tcu_exp_top.sv
`timescale 1ns/10ps
`include "tcu_macros.svh"

module tcu_exp_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    input  tcu_fmt_pkg::fmt_id_t                  fmt,
    input  logic [`TCU_MASK_W-1:0]                vld_mask,
    input  logic [`TCU_N-1:0][31:0]               a_row,
    input  logic [`TCU_N-1:0][31:0]               b_col,
    input  logic [31:0]                           c_val,
    output logic                                  out_valid,
    output tcu_fedp_pkg::exp_t                    max_exp,
    output tcu_fedp_pkg::shift_t   [`TCU_TCK:0]   shift_amt,
    output logic                   [`TCU_TCK:0]   zero_mask,
    output tcu_fedp_pkg::f8_diff_t [`TCU_TCK-1:0] diff_f8,
    output logic                                  any_special
);
    import tcu_fedp_pkg::*;

    exp_t     [`TCU_TCK:0]   raw_exp;
    f8_diff_t [`TCU_TCK-1:0] exp_diff_f8;

    tcu_operand_if ops (.clk(clk));

    // Stage 1, operand register and classes
    tcu_operand_classify u_classify (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .fmt      (fmt),
        .vld_mask (vld_mask),
        .a_row    (a_row),
        .b_col    (b_col),
        .c_val    (c_val),
        .ops      (ops)
    );

    tcu_exp_bias u_bias (
        .ops         (ops),
        .raw_exp     (raw_exp),
        .exp_diff_f8 (exp_diff_f8)
    );

    // Stage 2, max search and shifts
    tcu_exp_align u_align (
        .clk            (clk),
        .rst            (rst),
        .valid          (ops.valid),
        .raw_exp        (raw_exp),
        .exp_diff_f8    (exp_diff_f8),
        .any_special_in (ops.any_special),
        .out_valid      (out_valid),
        .max_exp        (max_exp),
        .shift_amt      (shift_amt),
        .zero_mask      (zero_mask),
        .diff_f8        (diff_f8),
        .any_special    (any_special)
    );

endmodule

// File: tcu_fedp_pkg.sv
`include "tcu_macros.svh"

package tcu_fedp_pkg;

    // Biased exponent in the product domain, read as signed
    typedef logic [`TCU_EXP_W-1:0] exp_t;

    // Alignment shift amount
    typedef logic [5:0] shift_t;

    localparam shift_t SHIFT_MAX = 6'd63;

    // Sign in bit 5, magnitude below
    typedef logic [5:0] f8_diff_t;

    // Element class flags
    typedef struct packed {
        logic is_zero;
        logic is_sub;
        logic is_inf;
        logic is_nan;
    } elem_class_t;

endpackage

// File: tcu_fmt_pkg.sv
package tcu_fmt_pkg;

    // Operation format code
    typedef logic [2:0] fmt_id_t;

    localparam fmt_id_t FMT_TF32 = 3'd0;
    localparam fmt_id_t FMT_FP16 = 3'd1;
    localparam fmt_id_t FMT_BF16 = 3'd2;
    localparam fmt_id_t FMT_FP8  = 3'd3;
    localparam fmt_id_t FMT_BF8  = 3'd4;

    function automatic logic fmt_defined(fmt_id_t fmt);
        return fmt inside {FMT_TF32, FMT_FP16, FMT_BF16, FMT_FP8, FMT_BF8};
    endfunction

    // Exponent field width
    function automatic int exp_bits(fmt_id_t fmt);
        case (fmt)
            FMT_FP16: return 5;
            FMT_FP8:  return 4;
            FMT_BF8:  return 5;
            default:  return 8;
        endcase
    endfunction

    // Sign bit inside one element, TF32 lives in the low 19 bits
    function automatic int sign_pos(fmt_id_t fmt);
        case (fmt)
            FMT_TF32: return 18;
            FMT_FP16: return 15;
            FMT_BF16: return 15;
            default:  return 7;
        endcase
    endfunction

    // Mantissa sits below the exponent field
    function automatic int man_bits(fmt_id_t fmt);
        return sign_pos(fmt) - exp_bits(fmt);
    endfunction

    function automatic int exp_bias(fmt_id_t fmt);
        return (1 << (exp_bits(fmt) - 1)) - 1;
    endfunction

endpackage

// File: tcu_macros.svh
`ifndef TCU_MACROS_SVH
`define TCU_MACROS_SVH

// Words per row and column
`define TCU_N 2

// Product lanes per dot product
`define TCU_TCK 4

// Accumulator window width
`define TCU_W 25

// Product-domain exponent width
`define TCU_EXP_W 10

// One valid bit per byte element slot
`define TCU_MASK_W 16

`endif

// File: tcu_operand_classify.sv
`timescale 1ns/10ps
`include "tcu_macros.svh"

module tcu_operand_classify (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  tcu_fmt_pkg::fmt_id_t    fmt,
    input  logic [`TCU_MASK_W-1:0]  vld_mask,
    input  logic [`TCU_N-1:0][31:0] a_row,
    input  logic [`TCU_N-1:0][31:0] b_col,
    input  logic [31:0]             c_val,
    tcu_operand_if.producer         ops
);
    import tcu_fmt_pkg::*;
    import tcu_fedp_pkg::*;

    localparam int N   = `TCU_N;
    localparam int TCK = `TCU_TCK;

    logic [1:0][N-1:0][31:0]      opnd;
    elem_class_t [1:0][N-1:0]     tf32_d;
    elem_class_t [1:0][TCK-1:0]   fp16_d;
    elem_class_t [1:0][TCK-1:0]   bf16_d;
    elem_class_t [1:0][2*TCK-1:0] fp8_d;
    elem_class_t [1:0][2*TCK-1:0] bf8_d;
    elem_class_t                  c_d;
    logic                         special_d;

    function automatic elem_class_t classify(logic [31:0] word, int off, int ebits, int mbits);
        logic [31:0] fld;
        logic [31:0] e;
        logic [31:0] m;
        elem_class_t c;
        fld       = word >> off;
        m         = fld & ((32'd1 << mbits) - 32'd1);
        e         = (fld >> mbits) & ((32'd1 << ebits) - 32'd1);
        c.is_zero = (e == 0) && (m == 0);
        c.is_sub  = (e == 0) && (m != 0);
        c.is_inf  = (e == (32'd1 << ebits) - 32'd1) && (m == 0);
        c.is_nan  = (e == (32'd1 << ebits) - 32'd1) && (m != 0);
        return c;
    endfunction

    function automatic logic special(elem_class_t c);
        return c.is_inf | c.is_nan;
    endfunction

    assign opnd = {b_col, a_row};

    // ----------------------------------------
    // Element decode per format
    // ----------------------------------------
    for (genvar s = 0; s < 2; s++) begin : g_side
        for (genvar e = 0; e < N; e++) begin : g_tf32
            assign tf32_d[s][e] = classify(opnd[s][e], 0, exp_bits(FMT_TF32), man_bits(FMT_TF32));
        end
        for (genvar e = 0; e < TCK; e++) begin : g_half
            localparam int OFF = (e % 2) * 16;
            assign fp16_d[s][e] = classify(opnd[s][e/2], OFF, exp_bits(FMT_FP16),
                                           man_bits(FMT_FP16));
            assign bf16_d[s][e] = classify(opnd[s][e/2], OFF, exp_bits(FMT_BF16),
                                           man_bits(FMT_BF16));
        end
        for (genvar e = 0; e < 2*TCK; e++) begin : g_byte
            localparam int OFF = (e % 4) * 8;
            assign fp8_d[s][e] = classify(opnd[s][e/4], OFF, exp_bits(FMT_FP8), man_bits(FMT_FP8));
            assign bf8_d[s][e] = classify(opnd[s][e/4], OFF, exp_bits(FMT_BF8), man_bits(FMT_BF8));
        end
    end

    // C is always FP32
    assign c_d = classify(c_val, 0, 8, 23);

    // Inf/NaN only counts for the active format
    always_comb begin
        special_d = special(c_d);
        for (int s = 0; s < 2; s++) begin
            for (int e = 0; e < 2*TCK; e++) begin
                case (fmt)
                    FMT_TF32: special_d |= (e < N) && special(tf32_d[s][e % N]);
                    FMT_FP16: special_d |= (e < TCK) && special(fp16_d[s][e % TCK]);
                    FMT_BF16: special_d |= (e < TCK) && special(bf16_d[s][e % TCK]);
                    FMT_FP8:  special_d |= special(fp8_d[s][e]);
                    FMT_BF8:  special_d |= special(bf8_d[s][e]);
                    default:  special_d |= 1'b0;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Operand register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ops.valid <= 1'b0;
        end else begin
            ops.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            ops.fmt         <= fmt;
            ops.vld_mask    <= vld_mask;
            ops.a_row       <= a_row;
            ops.b_col       <= b_col;
            ops.c_val       <= c_val;
            ops.cls_tf32    <= tf32_d;
            ops.cls_fp16    <= fp16_d;
            ops.cls_bf16    <= bf16_d;
            ops.cls_fp8     <= fp8_d;
            ops.cls_bf8     <= bf8_d;
            ops.cls_c       <= c_d;
            ops.any_special <= special_d;
        end
    end

    a_in_fmt: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> fmt_defined(fmt))
        else $error("undefined fmt accepted with in_valid");

endmodule

// File: tcu_operand_if.sv
`timescale 1ns/10ps
`include "tcu_macros.svh"

interface tcu_operand_if (
    input logic clk
);
    import tcu_fmt_pkg::*;
    import tcu_fedp_pkg::*;

    logic                              valid;
    fmt_id_t                           fmt;
    logic [`TCU_MASK_W-1:0]            vld_mask;
    logic [`TCU_N-1:0][31:0]           a_row;
    logic [`TCU_N-1:0][31:0]           b_col;
    logic [31:0]                       c_val;

    // Element classes, index 0 is the A side
    elem_class_t [1:0][`TCU_N-1:0]     cls_tf32;
    elem_class_t [1:0][`TCU_TCK-1:0]   cls_fp16;
    elem_class_t [1:0][`TCU_TCK-1:0]   cls_bf16;
    elem_class_t [1:0][2*`TCU_TCK-1:0] cls_fp8;
    elem_class_t [1:0][2*`TCU_TCK-1:0] cls_bf8;
    elem_class_t                       cls_c;

    // Any Inf or NaN in the active format
    logic                              any_special;

    modport producer (
        input  clk,
        output valid, fmt, vld_mask, a_row, b_col, c_val,
        output cls_tf32, cls_fp16, cls_bf16, cls_fp8, cls_bf8, cls_c, any_special
    );

    modport consumer (
        input  clk,
        input  valid, fmt, vld_mask, a_row, b_col, c_val,
        input  cls_tf32, cls_fp16, cls_bf16, cls_fp8, cls_bf8, cls_c, any_special
    );

endinterface
